// File: Bender.yml
package:
  name: dsp_hub

sources:
  - design/dsp_pkg.sv
  - design/dsp_config_regs.sv
  - design/dsp_signal_router.sv
  - design/dsp_dac_summer.sv
  - design/dsp_hub_top.sv
  - target: test
    files:
      - test/dsp_tb_clock.sv
      - test/dsp_hub_assertions.sv
      - test/dsp_hub_tb.sv

// File: design/dsp_config_regs.sv
// ----------------------------------------
// bus register bank of the signal hub
// one-cycle strobes, ack on the next edge
// read data valid only with the ack
// unknown offsets and bad indices read 0
// sys_err_o never rises
// ----------------------------------------
module dsp_config_regs #(
   parameter int  NUM_SLOTS = 8,
   localparam int NUM_SRC   = NUM_SLOTS + dsp_pkg::SRC_EXTRA,
   localparam int NUM_DST   = NUM_SLOTS + dsp_pkg::DST_EXTRA,
   localparam int NUM_DIR   = NUM_SLOTS + dsp_pkg::DIR_EXTRA
) (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic [dsp_pkg::BUS_W-1:0] sys_addr_i,
   input  logic [dsp_pkg::BUS_W-1:0] sys_wdata_i,
   input  logic                      sys_wen_i,
   input  logic                      sys_ren_i,
   input  dsp_pkg::sample_t          src_i [NUM_SRC],
   input  logic                      sat_a_i,
   input  logic                      sat_b_i,
   output logic [dsp_pkg::BUS_W-1:0] sys_rdata_o,
   output logic                      sys_ack_o,
   output logic                      sys_err_o,
   output dsp_pkg::src_sel_t         in_sel_o [NUM_DST],
   output dsp_pkg::out_sel_e         out_sel_o [NUM_DIR],
   output logic [NUM_SLOTS-1:0]      sync_o
);

   dsp_pkg::reg_off_e         offset;  // may hold a non-member code, caught by default
   logic [dsp_pkg::IDX_W-1:0] idx;     // destination or source number
   logic [dsp_pkg::BUS_W-1:0] rd_word;

   assign offset = dsp_pkg::reg_off_e'(sys_addr_i[dsp_pkg::OFF_W-1:0]);
   assign idx    = sys_addr_i[dsp_pkg::IDX_LSB +: dsp_pkg::IDX_W];

   // routing and sync registers
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int d = 0; d < NUM_DST; d++) begin
            in_sel_o[d] <= dsp_pkg::rst_in_sel(NUM_SLOTS, d);
         end
         for (int s = 0; s < NUM_DIR; s++) begin
            out_sel_o[s] <= dsp_pkg::RST_OUT_SEL;
         end
         sync_o <= {NUM_SLOTS{dsp_pkg::RST_SYNC}};
      end else if (sys_wen_i) begin
         case (offset)
            dsp_pkg::IN_SEL: begin
               if (idx < NUM_DST)
                  in_sel_o[idx] <= sys_wdata_i[dsp_pkg::SEL_W-1:0];
            end
            dsp_pkg::OUT_SEL: begin
               if (idx < NUM_DIR)   // only direct outputs have a dac select
                  out_sel_o[idx] <=
                     dsp_pkg::out_sel_e'(sys_wdata_i[dsp_pkg::OSEL_W-1:0]);
            end
            dsp_pkg::SYNC: sync_o <= sys_wdata_i[NUM_SLOTS-1:0];
            default: ;               // sat, src_val and holes are read only
         endcase
      end
   end

   // read word, sampled at the strobe edge
   always_comb begin
      rd_word = '0;
      case (offset)
         dsp_pkg::IN_SEL: begin
            if (idx < NUM_DST)
               rd_word[dsp_pkg::SEL_W-1:0] = in_sel_o[idx];
         end
         dsp_pkg::OUT_SEL: begin
            if (idx < NUM_DIR)
               rd_word[dsp_pkg::OSEL_W-1:0] = out_sel_o[idx];
         end
         dsp_pkg::SAT:  rd_word[1:0] = {sat_b_i, sat_a_i}; // bit 0 dac a
         dsp_pkg::SYNC: rd_word[NUM_SLOTS-1:0] = sync_o;
         dsp_pkg::SRC_VAL: begin
            // raw 14-bit pattern, upper bits zero
            if (idx < NUM_SRC)
               rd_word[dsp_pkg::DAT_W-1:0] = src_i[idx];
         end
         default: rd_word = '0;
      endcase
   end

   // acknowledge one cycle after any strobe
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sys_ack_o <= 1'b0;
         sys_err_o <= 1'b0;
      end else begin
         sys_ack_o <= sys_wen_i | sys_ren_i;
         sys_err_o <= 1'b0;   // no error source left in the hub
      end
   end

   always_ff @(posedge clk_i) begin
      if (sys_ren_i)
         sys_rdata_o <= rd_word;
   end

endmodule

// File: design/dsp_dac_summer.sv
// ----------------------------------------
// sum of enabled direct outputs per dac
// latency SUM_LATENCY cycles, 16 leaves
// NUM_DIR must not exceed 16
// flags are aligned with the dac value
// ----------------------------------------
module dsp_dac_summer #(
   parameter int  NUM_SLOTS = 8,
   localparam int NUM_DIR   = NUM_SLOTS + dsp_pkg::DIR_EXTRA
) (
   input  logic              clk_i,
   input  logic              rstn_i,
   input  dsp_pkg::sample_t  direct_i [NUM_DIR],
   input  dsp_pkg::out_sel_e out_sel_i [NUM_DIR],
   output dsp_pkg::sample_t  dac_a_o,
   output dsp_pkg::sample_t  dac_b_o,
   output logic              sat_a_o,
   output logic              sat_b_o
);

   typedef logic signed [dsp_pkg::SUM_W-1:0] sum_t;

   localparam int   NUM_CH  = 2;                                  // ch 0 dac a, ch 1 dac b
   localparam int   LEAVES  = 2 ** (dsp_pkg::SUM_LATENCY - 1);    // 4 add levels + out reg
   localparam sum_t MAX_VAL = sum_t'(2 ** (dsp_pkg::DAT_W - 1) - 1);
   localparam sum_t MIN_VAL = sum_t'(-(2 ** (dsp_pkg::DAT_W - 1)));

   sum_t             leaf   [NUM_CH][LEAVES];
   sum_t             node_q [NUM_CH][LEAVES-1]; // heap, root at LEAVES-2
   sum_t             sum_q  [NUM_CH];
   dsp_pkg::sample_t dac    [NUM_CH];
   logic             sat    [NUM_CH];

   // sign extend and mask by the channel bit
   always_comb begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
         for (int i = 0; i < LEAVES; i++) begin
            leaf[ch][i] = '0;                 // padding leaves
         end
         for (int i = 0; i < NUM_DIR; i++) begin
            leaf[ch][i] = out_sel_i[i][ch] ? sum_t'(direct_i[i]) : '0;
         end
      end
   end

   // pair sums, then three tree levels, then output register
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int ch = 0; ch < NUM_CH; ch++) begin
            for (int n = 0; n < LEAVES - 1; n++) begin
               node_q[ch][n] <= '0;
            end
            sum_q[ch] <= '0;   // dac starts at midscale
         end
      end else begin
         for (int ch = 0; ch < NUM_CH; ch++) begin
            for (int n = 0; n < LEAVES / 2; n++) begin
               node_q[ch][n] <= leaf[ch][2*n] + leaf[ch][2*n+1];
            end
            // node LEAVES/2+n adds nodes 2n and 2n+1
            for (int n = 0; n < LEAVES / 2 - 1; n++) begin
               node_q[ch][LEAVES/2+n] <= node_q[ch][2*n] + node_q[ch][2*n+1];
            end
            sum_q[ch] <= node_q[ch][LEAVES-2];
         end
      end
   end

   // clamp to the 14-bit range
   always_comb begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
         dac[ch] = sum_q[ch][dsp_pkg::DAT_W-1:0];
         sat[ch] = 1'b0;
         if (sum_q[ch] > MAX_VAL) begin
            dac[ch] = dsp_pkg::sample_t'(MAX_VAL);
            sat[ch] = 1'b1;
         end else if (sum_q[ch] < MIN_VAL) begin
            dac[ch] = dsp_pkg::sample_t'(MIN_VAL);
            sat[ch] = 1'b1;
         end
      end
   end

   assign dac_a_o = dac[0];
   assign dac_b_o = dac[1];
   assign sat_a_o = sat[0];
   assign sat_b_o = sat[1];

endmodule

// File: design/dsp_hub_top.sv
// ----------------------------------------
// signal hub of the servo controller
// processing slots sit outside, each one
// sends one sample and gets one back
// dac outputs loop back as sources
// ----------------------------------------
module dsp_hub_top #(
   parameter int  NUM_SLOTS = 8,
   localparam int NUM_SRC   = NUM_SLOTS + dsp_pkg::SRC_EXTRA,
   localparam int NUM_DST   = NUM_SLOTS + dsp_pkg::DST_EXTRA,
   localparam int NUM_DIR   = NUM_SLOTS + dsp_pkg::DIR_EXTRA
) (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic [dsp_pkg::BUS_W-1:0] sys_addr_i,
   input  logic [dsp_pkg::BUS_W-1:0] sys_wdata_i,
   input  logic                      sys_wen_i,
   input  logic                      sys_ren_i,
   output logic [dsp_pkg::BUS_W-1:0] sys_rdata_o,
   output logic                      sys_ack_o,
   output logic                      sys_err_o,
   input  dsp_pkg::sample_t          adc_a_i,
   input  dsp_pkg::sample_t          adc_b_i,
   input  dsp_pkg::sample_t          asg1_i,
   input  dsp_pkg::sample_t          asg2_i,
   input  dsp_pkg::sample_t          slot_dat_i [NUM_SLOTS],
   output dsp_pkg::sample_t          slot_in_o [NUM_SLOTS],
   output logic [NUM_SLOTS-1:0]      sync_o,
   output dsp_pkg::sample_t          scope1_o,
   output dsp_pkg::sample_t          scope2_o,
   output dsp_pkg::sample_t          pwm0_o,
   output dsp_pkg::sample_t          pwm1_o,
   output dsp_pkg::sample_t          dac_a_o,
   output dsp_pkg::sample_t          dac_b_o
);

   wire dsp_pkg::sample_t  direct [NUM_DIR]; // sources that can reach the dacs
   wire dsp_pkg::sample_t  src    [NUM_SRC];
   dsp_pkg::src_sel_t      in_sel  [NUM_DST];
   dsp_pkg::out_sel_e      out_sel [NUM_DIR];
   logic                   sat_a;
   logic                   sat_b;

   for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
      assign direct[s] = slot_dat_i[s];
   end
   assign direct[NUM_SLOTS + dsp_pkg::SRC_OFS_ASG1] = asg1_i;
   assign direct[NUM_SLOTS + dsp_pkg::SRC_OFS_ASG2] = asg2_i;

   for (genvar d = 0; d < NUM_DIR; d++) begin : g_dir
      assign src[d] = direct[d];
   end
   assign src[NUM_SLOTS + dsp_pkg::SRC_OFS_ADC_A] = adc_a_i;
   assign src[NUM_SLOTS + dsp_pkg::SRC_OFS_ADC_B] = adc_b_i;
   assign src[NUM_SLOTS + dsp_pkg::SRC_OFS_DAC_A] = dac_a_o; // after the output register
   assign src[NUM_SLOTS + dsp_pkg::SRC_OFS_DAC_B] = dac_b_o;

   dsp_config_regs #(.NUM_SLOTS(NUM_SLOTS)) u_regs (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .src_i       (src),
      .sat_a_i     (sat_a),
      .sat_b_i     (sat_b),
      .sys_rdata_o (sys_rdata_o),
      .sys_ack_o   (sys_ack_o),
      .sys_err_o   (sys_err_o),
      .in_sel_o    (in_sel),
      .out_sel_o   (out_sel),
      .sync_o      (sync_o)
   );

   dsp_signal_router #(.NUM_SLOTS(NUM_SLOTS)) u_router (
      .src_i     (src),
      .in_sel_i  (in_sel),
      .slot_in_o (slot_in_o),
      .scope1_o  (scope1_o),
      .scope2_o  (scope2_o),
      .pwm0_o    (pwm0_o),
      .pwm1_o    (pwm1_o)
   );

   dsp_dac_summer #(.NUM_SLOTS(NUM_SLOTS)) u_summer (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .direct_i  (direct),
      .out_sel_i (out_sel),
      .dac_a_o   (dac_a_o),
      .dac_b_o   (dac_b_o),
      .sat_a_o   (sat_a),
      .sat_b_o   (sat_b)
   );

endmodule

// File: design/dsp_pkg.sv
// ----------------------------------------
// shared widths, numbering and defaults
// sources and destinations above the slots
// are offsets added to NUM_SLOTS
// select width 4 limits NUM_SLOTS to 9
// ----------------------------------------
package dsp_pkg;

   localparam int DAT_W       = 14;            // adc/dac sample width
   localparam int SEL_W       = 4;             // source number width
   localparam int OSEL_W      = 2;             // output select width
   localparam int SUM_W       = DAT_W + SEL_W; // room for 16 summed samples
   localparam int SUM_LATENCY = 5;             // summer depth in cycles

   // system bus fields
   localparam int BUS_W   = 32;
   localparam int OFF_W   = 16; // register offset, low address bits
   localparam int IDX_LSB = 16; // index at addr[19:16]
   localparam int IDX_W   = 4;

   typedef logic signed [DAT_W-1:0] sample_t;
   typedef logic [SEL_W-1:0]        src_sel_t;

   localparam src_sel_t SRC_NONE = src_sel_t'(2 ** SEL_W - 1); // routes zero

   // source numbers above the slot outputs
   localparam int SRC_OFS_ASG1  = 0;
   localparam int SRC_OFS_ASG2  = 1;
   localparam int SRC_OFS_ADC_A = 2;
   localparam int SRC_OFS_ADC_B = 3;
   localparam int SRC_OFS_DAC_A = 4;
   localparam int SRC_OFS_DAC_B = 5;
   localparam int SRC_EXTRA     = 6;
   localparam int DIR_EXTRA     = 2; // asg1/asg2 also feed the dac sum

   // destination numbers above the slot inputs
   localparam int DST_OFS_SCOPE1 = 0;
   localparam int DST_OFS_SCOPE2 = 1;
   localparam int DST_OFS_PWM0   = 2;
   localparam int DST_OFS_PWM1   = 3;
   localparam int DST_EXTRA      = 4;

   // bit 0 adds to dac a, bit 1 to dac b
   typedef enum logic [OSEL_W-1:0] {
      OFF  = 2'b00,
      OUT1 = 2'b01,
      OUT2 = 2'b10,
      BOTH = 2'b11
   } out_sel_e;

   typedef enum logic [OFF_W-1:0] {
      IN_SEL  = 16'h0000,
      OUT_SEL = 16'h0004,
      SAT     = 16'h0008,
      SYNC    = 16'h000C,
      SRC_VAL = 16'h0010
   } reg_off_e;

   localparam out_sel_e RST_OUT_SEL = OFF;
   localparam logic     RST_SYNC    = 1'b1; // every slot enabled

   // default input routing, as on the stock board
   function automatic src_sel_t rst_in_sel(int num_slots, int dst);
      if (dst < num_slots)
         return src_sel_t'(num_slots + SRC_OFS_ADC_A);
      else if (dst == num_slots + DST_OFS_SCOPE1)
         return src_sel_t'(num_slots + SRC_OFS_ADC_A);
      else if (dst == num_slots + DST_OFS_SCOPE2)
         return src_sel_t'(num_slots + SRC_OFS_ADC_B);
      else
         return SRC_NONE; // pwm channels off
   endfunction

endpackage

// File: design/dsp_signal_router.sv
// ----------------------------------------
// source select for every destination
// purely combinational, zero latency
// NONE or codes past the last source
// give zero
// ----------------------------------------
module dsp_signal_router #(
   parameter int  NUM_SLOTS = 8,
   localparam int NUM_SRC   = NUM_SLOTS + dsp_pkg::SRC_EXTRA,
   localparam int NUM_DST   = NUM_SLOTS + dsp_pkg::DST_EXTRA
) (
   input  dsp_pkg::sample_t  src_i [NUM_SRC],
   input  dsp_pkg::src_sel_t in_sel_i [NUM_DST],
   output dsp_pkg::sample_t  slot_in_o [NUM_SLOTS],
   output dsp_pkg::sample_t  scope1_o,
   output dsp_pkg::sample_t  scope2_o,
   output dsp_pkg::sample_t  pwm0_o,
   output dsp_pkg::sample_t  pwm1_o
);

   // one source mux
   function automatic dsp_pkg::sample_t route(dsp_pkg::src_sel_t sel);
      if (sel == dsp_pkg::SRC_NONE || sel >= NUM_SRC)
         return '0;    // unused code, output muted
      else
         return src_i[sel];
   endfunction

   always_comb begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
         slot_in_o[s] = route(in_sel_i[s]);  // slot input data
      end
      scope1_o = route(in_sel_i[NUM_SLOTS + dsp_pkg::DST_OFS_SCOPE1]);
      scope2_o = route(in_sel_i[NUM_SLOTS + dsp_pkg::DST_OFS_SCOPE2]);
      pwm0_o   = route(in_sel_i[NUM_SLOTS + dsp_pkg::DST_OFS_PWM0]);
      pwm1_o   = route(in_sel_i[NUM_SLOTS + dsp_pkg::DST_OFS_PWM1]);
   end

endmodule

// File: flist.f
design/dsp_pkg.sv
design/dsp_config_regs.sv
design/dsp_signal_router.sv
design/dsp_dac_summer.sv
design/dsp_hub_top.sv
test/dsp_tb_clock.sv
test/dsp_hub_assertions.sv
test/dsp_hub_tb.sv

// File: test/dsp_hub_assertions.sv
// ----------------------------------------
// bound checks for the bus and the dacs
// one module, bound twice; ports a target
// does not have are tied off
// every failure also counts in fails
// ----------------------------------------
module dsp_hub_assertions (
   input logic             clk_i,
   input logic             rstn_i,
   input logic             strobe_i,
   input logic             ack_i,
   input logic             err_i,
   input logic             sat_a_i,
   input logic             sat_b_i,
   input dsp_pkg::sample_t dac_a_i,
   input dsp_pkg::sample_t dac_b_i
);

   localparam dsp_pkg::sample_t MAX_S = 14'sh1FFF;
   localparam dsp_pkg::sample_t MIN_S = 14'sh2000;

   int fails = 0;   // failed assertions so far

   ack_follows_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
      strobe_i |=> ack_i)
      else begin
         fails++;
         $error("no ack one cycle after a strobe");
      end

   ack_needs_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !strobe_i |=> !ack_i)
      else begin
         fails++;
         $error("ack without a strobe");
      end

   err_stays_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !err_i)
      else begin
         fails++;
         $error("bus error raised");
      end

   // flag only while clamped
   sat_a_at_limit: assert property (@(posedge clk_i) disable iff (!rstn_i)
      sat_a_i |-> (dac_a_i == MAX_S || dac_a_i == MIN_S))
      else begin
         fails++;
         $error("dac a flag off limit");
      end

   sat_b_at_limit: assert property (@(posedge clk_i) disable iff (!rstn_i)
      sat_b_i |-> (dac_b_i == MAX_S || dac_b_i == MIN_S))
      else begin
         fails++;
         $error("dac b flag off limit");
      end

endmodule

bind dsp_config_regs dsp_hub_assertions u_bus_chk (
   .clk_i (clk_i), .rstn_i (rstn_i), .strobe_i (sys_wen_i | sys_ren_i),
   .ack_i (sys_ack_o), .err_i (sys_err_o), .sat_a_i (1'b0), .sat_b_i (1'b0),
   .dac_a_i ('0), .dac_b_i ('0)
);

bind dsp_dac_summer dsp_hub_assertions u_sat_chk (
   .clk_i (clk_i), .rstn_i (rstn_i), .strobe_i (1'b0), .ack_i (1'b0),
   .err_i (1'b0), .sat_a_i (sat_a_o), .sat_b_i (sat_b_o),
   .dac_a_i (dac_a_o), .dac_b_i (dac_b_o)
);

// File: test/dsp_hub_tb.sv
// ----------------------------------------
// signal hub testbench, seed 75
// model tracks registers, sources and a
// 5-deep queue of dac sums
// inputs change 2 units after each edge
// ----------------------------------------
module dsp_hub_tb;

   localparam int NUM_SLOTS = 8;
   localparam int NUM_SRC   = NUM_SLOTS + 6;
   localparam int NUM_DST   = NUM_SLOTS + 4;
   localparam int NUM_DIR   = NUM_SLOTS + 2;
   localparam int DRV_DLY   = 2;
   localparam int ACK_TMO   = 8;    // cycles per bus access
   localparam int LATENCY   = 5;    // summer depth
   localparam int LIM       = 8191; // 14-bit signed max

   logic                 clk;
   logic                 rstn;
   logic [31:0]          addr;
   logic [31:0]          wdata;
   logic [31:0]          rdata;
   logic                 wen;
   logic                 ren;
   logic                 ack;
   logic                 err;
   dsp_pkg::sample_t     adc_a;
   dsp_pkg::sample_t     adc_b;
   dsp_pkg::sample_t     asg1;
   dsp_pkg::sample_t     asg2;
   dsp_pkg::sample_t     slot_dat [NUM_SLOTS];
   dsp_pkg::sample_t     slot_in  [NUM_SLOTS];
   logic [NUM_SLOTS-1:0] sync;
   dsp_pkg::sample_t     scope1;
   dsp_pkg::sample_t     scope2;
   dsp_pkg::sample_t     pwm0;
   dsp_pkg::sample_t     pwm1;
   dsp_pkg::sample_t     dac_a;
   dsp_pkg::sample_t     dac_b;

   // model state
   dsp_pkg::src_sel_t    in_sel_sh  [NUM_DST];
   dsp_pkg::out_sel_e    out_sel_sh [NUM_DIR];
   logic [NUM_SLOTS-1:0] sync_sh;
   int                   sum_q_a [$];       // sums in flight
   int                   sum_q_b [$];
   int                   sum_a;             // sum behind dac a now
   int                   sum_b;
   int                   seed = 75;
   int                   errors;
   int                   checks;
   int                   tests;

   dsp_tb_clock #(.PERIOD(40), .RST_CYCLES(4)) u_clk (.clk_o(clk), .rstn_o(rstn));

   dsp_hub_top #(.NUM_SLOTS(NUM_SLOTS)) uut (
      .clk_i (clk), .rstn_i (rstn), .sys_addr_i (addr), .sys_wdata_i (wdata),
      .sys_wen_i (wen), .sys_ren_i (ren), .sys_rdata_o (rdata), .sys_ack_o (ack),
      .sys_err_o (err), .adc_a_i (adc_a), .adc_b_i (adc_b), .asg1_i (asg1),
      .asg2_i (asg2), .slot_dat_i (slot_dat), .slot_in_o (slot_in), .sync_o (sync),
      .scope1_o (scope1), .scope2_o (scope2), .pwm0_o (pwm0), .pwm1_o (pwm1),
      .dac_a_o (dac_a), .dac_b_o (dac_b)
   );

   function automatic logic saturates(int s);
      return (s > LIM) || (s < -LIM - 1);
   endfunction

   function automatic dsp_pkg::sample_t clamp(int s);
      if (s > LIM)
         return dsp_pkg::sample_t'(LIM);
      if (s < -LIM - 1)
         return dsp_pkg::sample_t'(-LIM - 1);
      return dsp_pkg::sample_t'(s);
   endfunction

   // reset routing: slots and scope1 on adc a, scope2 on adc b, pwm off
   function automatic dsp_pkg::src_sel_t default_sel(int d);
      if (d < NUM_SLOTS || d == NUM_SLOTS)
         return 4'd10;
      if (d == NUM_SLOTS + 1)
         return 4'd11;
      return (d < NUM_DST) ? 4'd15 : 4'd0;
   endfunction

   function automatic dsp_pkg::sample_t src_val(int i);
      if (i < NUM_SLOTS)
         return slot_dat[i];
      case (i - NUM_SLOTS)
         0: return asg1;
         1: return asg2;
         2: return adc_a;
         3: return adc_b;
         4: return clamp(sum_a);   // predicted dac, not the dut's
         5: return clamp(sum_b);
         default: return '0;
      endcase
   endfunction

   function automatic dsp_pkg::sample_t route_exp(dsp_pkg::src_sel_t sel);
      return (sel < NUM_SRC) ? src_val(sel) : '0;   // none and 14 mute
   endfunction

   function automatic int chan_sum(int ch);
      int s = 0;
      for (int i = 0; i < NUM_DIR; i++) begin
         if (out_sel_sh[i][ch])
            s += src_val(i);
      end
      return s;
   endfunction

   function automatic logic [31:0] exp_word(dsp_pkg::reg_off_e off, int idx);
      logic [31:0] w;
      w = '0;
      case (off)
         dsp_pkg::IN_SEL:  w[3:0] = (idx < NUM_DST) ? in_sel_sh[idx] : 4'd0;
         dsp_pkg::OUT_SEL: w[1:0] = (idx < NUM_DIR) ? out_sel_sh[idx] : 2'd0;
         dsp_pkg::SAT:     w[1:0] = {saturates(sum_b), saturates(sum_a)};
         dsp_pkg::SYNC:    w[NUM_SLOTS-1:0] = sync_sh;
         dsp_pkg::SRC_VAL: w[13:0] = (idx < NUM_SRC) ? src_val(idx) : 14'd0;
         default:          w = '0;
      endcase
      return w;
   endfunction

   task automatic check_sample(dsp_pkg::sample_t got, dsp_pkg::sample_t exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %0d exp %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_sel(dsp_pkg::src_sel_t got, dsp_pkg::src_sel_t exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %0d exp %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_out_sel(dsp_pkg::out_sel_e got, dsp_pkg::out_sel_e exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %0d exp %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h exp %h", $time, what, got, exp);
      end
   endtask

   // one clock, model advances with the dut
   task automatic cycle();
      sum_q_a.push_back(chan_sum(0));   // sampled at the coming edge
      sum_q_b.push_back(chan_sum(1));
      @(posedge clk);
      #DRV_DLY;
      if (sum_q_a.size() == LATENCY) begin
         sum_a = sum_q_a.pop_front();
         sum_b = sum_q_b.pop_front();
      end
   endtask

   task automatic drive_data();
      for (int s = 0; s < NUM_SLOTS; s++)
         slot_dat[s] = dsp_pkg::sample_t'($random(seed));
      asg1  = dsp_pkg::sample_t'($random(seed));
      asg2  = dsp_pkg::sample_t'($random(seed));
      adc_a = dsp_pkg::sample_t'($random(seed));
      adc_b = dsp_pkg::sample_t'($random(seed));
   endtask

   // every direct output near base, base up to 1023 above
   task automatic drive_level(int base);
      for (int s = 0; s < NUM_SLOTS; s++)
         slot_dat[s] = dsp_pkg::sample_t'(base + {$random(seed)} % 1024);
      asg1 = dsp_pkg::sample_t'(base + {$random(seed)} % 1024);
      asg2 = dsp_pkg::sample_t'(base + {$random(seed)} % 1024);
   endtask

   task automatic wait_ack();
      int n = 0;
      while (!ack) begin
         if (n == ACK_TMO) begin
            $display("timeout at %0t: no bus ack within %0d cycles", $time, ACK_TMO);
            errors++;
            return;
         end
         n++;
         cycle();
      end
   endtask

   task automatic write_reg(dsp_pkg::reg_off_e off, int idx, logic [31:0] data);
      addr  = {12'h000, 4'(idx), off};
      wdata = data;
      wen   = 1'b1;
      cycle();
      wen   = 1'b0;
      case (off)   // register changed at that edge
         dsp_pkg::IN_SEL:
            if (idx < NUM_DST) in_sel_sh[idx] = data[3:0];
         dsp_pkg::OUT_SEL:
            if (idx < NUM_DIR) out_sel_sh[idx] = dsp_pkg::out_sel_e'(data[1:0]);
         dsp_pkg::SYNC: sync_sh = data[NUM_SLOTS-1:0];
         default: ;
      endcase
      wait_ack();
   endtask

   // exp is taken before the strobe edge
   task automatic read_reg(dsp_pkg::reg_off_e off, int idx, output logic [31:0] exp,
                           output logic [31:0] got);
      exp  = exp_word(off, idx);
      addr = {12'h000, 4'(idx), off};
      ren  = 1'b1;
      cycle();
      ren  = 1'b0;
      wait_ack();
      got  = rdata;
   endtask

   task automatic check_routes();
      for (int s = 0; s < NUM_SLOTS; s++)
         check_sample(slot_in[s], route_exp(in_sel_sh[s]), "slot input");
      check_sample(scope1, route_exp(in_sel_sh[NUM_SLOTS]), "scope1");
      check_sample(scope2, route_exp(in_sel_sh[NUM_SLOTS + 1]), "scope2");
      check_sample(pwm0, route_exp(in_sel_sh[NUM_SLOTS + 2]), "pwm0");
      check_sample(pwm1, route_exp(in_sel_sh[NUM_SLOTS + 3]), "pwm1");
   endtask

   task automatic end_test(string name, int err0);
      tests++;
      if (errors == err0)
         $display("test %0d %s: ok", tests, name);
      else
         $display("test %0d %s: %0d errors", tests, name, errors - err0);
   endtask

   // test sequence, starts just after reset release
   task automatic run_tests();
      logic [31:0]       exp;
      logic [31:0]       got;
      int                err0;
      int                pick;
      int                idx;
      dsp_pkg::reg_off_e off;

      err0 = errors;
      check_word(32'(sync), 32'h0000_00FF, "sync port default");
      for (int i = 0; i < 16; i++) begin
         read_reg(dsp_pkg::IN_SEL, i, exp, got);
         check_sel(dsp_pkg::src_sel_t'(got[3:0]), default_sel(i), "in_sel default");
         read_reg(dsp_pkg::OUT_SEL, i, exp, got);
         check_out_sel(dsp_pkg::out_sel_e'(got[1:0]), dsp_pkg::OFF, "out_sel default");
         read_reg(dsp_pkg::SYNC, i, exp, got);
         check_word(got, 32'h0000_00FF, "sync default");
      end
      end_test("reset defaults", err0);

      err0 = errors;
      for (int k = 0; k < 48; k++) begin
         pick = {$random(seed)} % 3;
         idx  = $random(seed) & 15;
         off  = (pick == 0) ? dsp_pkg::IN_SEL : (pick == 1) ? dsp_pkg::OUT_SEL : dsp_pkg::SYNC;
         if (off == dsp_pkg::SYNC)
            idx = 0;   // single register
         write_reg(off, idx, $random(seed));
         read_reg(off, idx, exp, got);
         check_word(got, exp, "register readback");
         check_word(32'(sync), 32'(sync_sh), "sync port");
      end
      end_test("register readback", err0);

      err0 = errors;
      for (int r = 0; r < 6; r++) begin
         for (int d = 0; d < NUM_DST; d++)
            write_reg(dsp_pkg::IN_SEL, d, (r == 0 && d == NUM_DST - 1) ? 15 : $random(seed));
         for (int c = 0; c < 8; c++) begin
            drive_data();
            cycle();
            check_routes();
         end
      end
      end_test("routing", err0);

      err0 = errors;
      for (int r = 0; r < 3; r++) begin
         for (int d = 0; d < NUM_DIR; d++)
            write_reg(dsp_pkg::OUT_SEL, d, $random(seed));
         for (int c = 0; c < 16; c++) begin
            drive_data();
            cycle();
            check_sample(dac_a, clamp(sum_a), "dac a sum");
            check_sample(dac_b, clamp(sum_b), "dac b sum");
         end
      end
      end_test("dac summing", err0);

      err0 = errors;
      for (int d = 0; d < NUM_DIR; d++)
         write_reg(dsp_pkg::OUT_SEL, d, dsp_pkg::BOTH);
      drive_level(6144);
      repeat (LATENCY + 1) cycle();
      check_sample(dac_a, 14'sh1FFF, "dac a high clamp");
      check_sample(dac_b, 14'sh1FFF, "dac b high clamp");
      read_reg(dsp_pkg::SAT, 0, exp, got);
      check_word(got, 32'h3, "sat flags high");
      for (int d = 0; d < NUM_DIR; d++)
         write_reg(dsp_pkg::OUT_SEL, d, dsp_pkg::OUT1);
      drive_level(-7168);
      repeat (LATENCY + 1) cycle();
      check_sample(dac_a, 14'sh2000, "dac a low clamp");
      check_sample(dac_b, 14'sh0000, "dac b unused");
      read_reg(dsp_pkg::SAT, 0, exp, got);
      check_word(got, 32'h1, "sat flags low");
      end_test("saturation", err0);

      err0 = errors;
      for (int k = 0; k < 24; k++) begin
         drive_data();
         read_reg(dsp_pkg::SRC_VAL, $random(seed) & 15, exp, got);
         check_word(got, exp, "src_val readback");
      end
      end_test("source readback", err0);
   endtask

   initial begin
      int n;
      int afails;
      addr = '0;
      wdata = '0;
      wen = 1'b0;
      ren = 1'b0;
      adc_a = '0;
      adc_b = '0;
      for (int d = 0; d < NUM_DST; d++)
         in_sel_sh[d] = default_sel(d);
      for (int d = 0; d < NUM_DIR; d++)
         out_sel_sh[d] = dsp_pkg::OFF;
      sync_sh = '1;
      sum_a = 0;
      sum_b = 0;
      errors = 0;
      checks = 0;
      tests = 0;
      for (int s = 0; s < NUM_SLOTS; s++)
         slot_dat[s] = '0;
      asg1 = '0;
      asg2 = '0;
      n = 0;
      while (rstn !== 1'b1 && n < 20) begin
         n++;
         @(posedge clk);
      end
      if (rstn !== 1'b1) begin
         $display("reset never released");
         $display("=== FAIL ===");
      end else begin
         #DRV_DLY;
         run_tests();
         afails = uut.u_regs.u_bus_chk.fails + uut.u_summer.u_sat_chk.fails;
         if (afails != 0)
            $display("%0d assertion failures in the bound checkers", afails);
         errors += afails;
         $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
         if (errors == 0)
            $display("=== PASS ===");
         else
            $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: test/dsp_tb_clock.sv
// ----------------------------------------
// testbench clock and reset
// reset drops one time unit after the
// last reset edge, so it is synchronous
// ----------------------------------------
module dsp_tb_clock #(
   parameter int PERIOD     = 40,
   parameter int RST_CYCLES = 4
) (
   output logic clk_o,
   output logic rstn_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   initial begin
      rstn_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1 rstn_o = 1'b1;   // just after the edge
   end

endmodule
